//--- hdl/datapath_pkg.sv
package datapath_pkg;

    // --------------------
    // Widths and sizes.
    // --------------------

    localparam int unsigned word_width      = 16;
    localparam int unsigned opcode_width    = 4;
    localparam int unsigned dest_width      = 12;
    localparam int unsigned src_width       = 8;

    localparam int unsigned bank_depth      = 64;
    localparam int unsigned bank_addr_width = 6;
    localparam int unsigned io_port_count   = 2;

    // --------------------
    // Address map.
    // --------------------

    // I/O ports sit at the top of each bank's local window.
    // Local 62 is port 0, local 63 is port 1.
    localparam int unsigned io_base         = 62;

    // Start of each bank's window in the D address space.
    localparam int unsigned a_write_base    = 0;
    localparam int unsigned b_write_base    = 64;

    // --------------------
    // Types.
    // --------------------

    typedef logic [word_width-1:0] word_t;

    typedef enum logic [opcode_width-1:0] {
        nop    = 4'd0,
        add    = 4'd1,
        sub    = 4'd2,
        and_op = 4'd3,
        or_op  = 4'd4,
        xor_op = 4'd5,
        pass_a = 4'd6,
        pass_b = 4'd7
    } opcode_e;

    // Instruction word, opcode in the top nibble.
    typedef struct packed {
        opcode_e               opcode;
        logic [dest_width-1:0] d;
        logic [src_width-1:0]  a;
        logic [src_width-1:0]  b;
    } instr_t;

    // Instruction as seen after the issue decision.
    typedef struct packed {
        logic   valid;
        instr_t instr;
    } issue_t;

    // Result on its way back to the banks.
    typedef struct packed {
        logic                  valid;
        logic [dest_width-1:0] d;
        word_t                 data;
    } wb_t;

endpackage

//--- hdl/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
    input  logic                 clock,
    input  logic                 reset,

    input  datapath_pkg::instr_t instr,
    input  logic                 instr_valid,

    input  logic                 a_can_issue,
    input  logic                 b_can_issue,

    output datapath_pkg::issue_t issue,
    output logic                 io_ready
);

    import datapath_pkg::*;

    instr_t instr_q;
    logic   present_q;
    logic   is_nop;
    logic   ports_ready;

    // --------------------
    // Instruction register.
    // --------------------

    always_ff @(posedge clock) begin
        instr_q <= instr;
        if (reset) begin
            present_q <= 1'b0;
        end else begin
            present_q <= instr_valid;
        end
    end

    // --------------------
    // Decode.
    // --------------------

    always_comb begin
        is_nop      = (instr_q.opcode == nop);
        ports_ready = a_can_issue && b_can_issue;
    end

    // --------------------
    // Issue decision.
    // --------------------

    // A nop has no side effects, so it never waits on a port.
    // Anything else needs every port it names to be ready,
    // otherwise it is annulled and comes back on a later edge.
    assign io_ready = present_q && (is_nop || ports_ready);

    // Fields always pass through; the banks judge readiness from them.
    // Only the valid bit carries the outcome.
    always_comb begin
        issue.valid = present_q && !is_nop && ports_ready;
        issue.instr = instr_q;
    end

endmodule

//--- hdl/operand_bank.sv
`timescale 1ns/1ps

module operand_bank #(
    parameter int unsigned write_base = datapath_pkg::a_write_base
) (
    input  logic                                                  clock,
    input  logic                                                  reset,

    input  datapath_pkg::issue_t                                  issue,
    input  datapath_pkg::wb_t                                     wb,

    input  logic [datapath_pkg::io_port_count-1:0]                io_in_ready,
    input  datapath_pkg::word_t [datapath_pkg::io_port_count-1:0] io_in_data,
    input  logic [datapath_pkg::io_port_count-1:0]                io_out_ready,

    output logic                                                  can_issue,
    output datapath_pkg::word_t                                   operand,

    output logic [datapath_pkg::io_port_count-1:0]                io_rden,
    output logic [datapath_pkg::io_port_count-1:0]                io_wren,
    output datapath_pkg::word_t [datapath_pkg::io_port_count-1:0] io_out_data
);

    import datapath_pkg::*;

    localparam int unsigned port_sel_width = $clog2(io_port_count);

    // Bank A reads through the a field, bank B through the b field.
    localparam bit use_a = (write_base == a_write_base);

    word_t ram [bank_depth];

    logic [src_width-1:0]       rd_addr;
    logic                       rd_is_ram;
    logic                       rd_is_io;
    logic [port_sel_width-1:0]  rd_port;
    word_t                      rd_data;

    logic [bank_addr_width-1:0] dst_local;
    logic                       dst_hit;
    logic                       dst_is_io;
    logic [port_sel_width-1:0]  dst_port;

    logic [bank_addr_width-1:0] wb_local;
    logic                       wb_hit;
    logic                       wb_is_io;
    logic [port_sel_width-1:0]  wb_port;

    // True when a D address falls inside this bank's window.
    function automatic logic in_window(logic [dest_width-1:0] d);
        return (d >= write_base) && (d < write_base + bank_depth);
    endfunction

    // Offset of a D address from the window base.
    function automatic logic [bank_addr_width-1:0] local_addr(logic [dest_width-1:0] d);
        logic [dest_width-1:0] offset;
        offset = d - dest_width'(write_base);
        return offset[bank_addr_width-1:0];
    endfunction

    // I/O port number of a local address at or above io_base.
    function automatic logic [port_sel_width-1:0] io_port(logic [bank_addr_width-1:0] addr);
        logic [bank_addr_width-1:0] offset;
        offset = addr - bank_addr_width'(io_base);
        return offset[port_sel_width-1:0];
    endfunction

    // --------------------
    // Operand fetch.
    // --------------------

    always_comb begin
        rd_addr   = use_a ? issue.instr.a : issue.instr.b;
        rd_is_ram = (rd_addr < io_base);
        rd_is_io  = !rd_is_ram && (rd_addr < bank_depth);
        rd_port   = io_port(rd_addr[bank_addr_width-1:0]);
        if (rd_is_ram) begin
            rd_data = ram[rd_addr[bank_addr_width-1:0]];
        end else if (rd_is_io) begin
            rd_data = io_in_data[rd_port];
        end else begin
            // Beyond the window reads as zero.
            rd_data = '0;
        end
    end

    // The port is consumed in the issue cycle, data taken on its closing edge.
    always_comb begin
        for (int p = 0; p < io_port_count; p++) begin
            io_rden[p] = issue.valid && rd_is_io && (rd_port == port_sel_width'(p));
        end
    end

    always_ff @(posedge clock) begin
        operand <= rd_data;
    end

    // --------------------
    // Port readiness.
    // --------------------

    always_comb begin
        dst_local = local_addr(issue.instr.d);
        dst_hit   = in_window(issue.instr.d);
        dst_is_io = (dst_local >= io_base);
        dst_port  = io_port(dst_local);
        can_issue = 1'b1;
        if (rd_is_io && !io_in_ready[rd_port]) begin
            can_issue = 1'b0;
        end
        // Write space is checked now and must hold until the write lands.
        if (dst_hit && dst_is_io && !io_out_ready[dst_port]) begin
            can_issue = 1'b0;
        end
    end

    // --------------------
    // Writeback.
    // --------------------

    always_comb begin
        wb_local = local_addr(wb.d);
        wb_hit   = wb.valid && in_window(wb.d);
        wb_is_io = (wb_local >= io_base);
        wb_port  = io_port(wb_local);
    end

    always_ff @(posedge clock) begin
        if (wb_hit && !wb_is_io) begin
            ram[wb_local] <= wb.data;
        end
    end

    always_ff @(posedge clock) begin
        for (int p = 0; p < io_port_count; p++) begin
            if (wb_hit && wb_is_io && (wb_port == port_sel_width'(p))) begin
                io_out_data[p] <= wb.data;
            end
        end
    end

    // Write strobe lines up with the RAM commit edge.
    always_ff @(posedge clock) begin
        if (reset) begin
            io_wren <= '0;
        end else begin
            for (int p = 0; p < io_port_count; p++) begin
                io_wren[p] <= wb_hit && wb_is_io && (wb_port == port_sel_width'(p));
            end
        end
    end

endmodule

//--- hdl/alu_stage.sv
`timescale 1ns/1ps

module alu_stage (
    input  logic                                    clock,
    input  logic                                    reset,

    input  datapath_pkg::issue_t                    issue,
    input  datapath_pkg::word_t                     a_operand,
    input  datapath_pkg::word_t                     b_operand,

    output datapath_pkg::wb_t                       wb,
    output datapath_pkg::word_t                     result,
    output logic                                    result_valid,
    output logic [datapath_pkg::dest_width-1:0]     result_d
);

    import datapath_pkg::*;

    logic                  valid_q;
    opcode_e               opcode_q;
    logic [dest_width-1:0] d_q;
    word_t                 alu_out;

    // --------------------
    // Operand stage.
    // --------------------

    // Opcode and destination follow the operands by one register.
    always_ff @(posedge clock) begin
        opcode_q <= issue.instr.opcode;
        d_q      <= issue.instr.d;
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue.valid;
        end
    end

    // --------------------
    // ALU.
    // --------------------

    // Add and sub wrap at the word width.
    always_comb begin
        case (opcode_q)
            add:     alu_out = a_operand + b_operand;
            sub:     alu_out = a_operand - b_operand;
            and_op:  alu_out = a_operand & b_operand;
            or_op:   alu_out = a_operand | b_operand;
            xor_op:  alu_out = a_operand ^ b_operand;
            pass_a:  alu_out = a_operand;
            pass_b:  alu_out = b_operand;
            default: alu_out = '0;
        endcase
    end

    // --------------------
    // Result register.
    // --------------------

    always_ff @(posedge clock) begin
        wb.d    <= d_q;
        wb.data <= alu_out;
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= valid_q;
        end
    end

    assign result       = wb.data;
    assign result_valid = wb.valid;
    assign result_d     = wb.d;

endmodule

//--- hdl/datapath_top.sv
`timescale 1ns/1ps

module datapath_top (
    input  logic                                                  clock,
    input  logic                                                  reset,

    input  datapath_pkg::instr_t                                  instr,
    input  logic                                                  instr_valid,
    output logic                                                  io_ready,

    output datapath_pkg::word_t                                   result,
    output logic                                                  result_valid,
    output logic [datapath_pkg::dest_width-1:0]                   result_d,

    input  logic [datapath_pkg::io_port_count-1:0]                a_io_in_ready,
    output logic [datapath_pkg::io_port_count-1:0]                a_io_rden,
    input  datapath_pkg::word_t [datapath_pkg::io_port_count-1:0] a_io_in_data,
    input  logic [datapath_pkg::io_port_count-1:0]                a_io_out_ready,
    output logic [datapath_pkg::io_port_count-1:0]                a_io_wren,
    output datapath_pkg::word_t [datapath_pkg::io_port_count-1:0] a_io_out_data,

    input  logic [datapath_pkg::io_port_count-1:0]                b_io_in_ready,
    output logic [datapath_pkg::io_port_count-1:0]                b_io_rden,
    input  datapath_pkg::word_t [datapath_pkg::io_port_count-1:0] b_io_in_data,
    input  logic [datapath_pkg::io_port_count-1:0]                b_io_out_ready,
    output logic [datapath_pkg::io_port_count-1:0]                b_io_wren,
    output datapath_pkg::word_t [datapath_pkg::io_port_count-1:0] b_io_out_data
);

    import datapath_pkg::*;

    issue_t issue;
    wb_t    wb;
    logic   a_can_issue;
    logic   b_can_issue;
    word_t  a_operand;
    word_t  b_operand;

    // --------------------
    // Issue.
    // --------------------

    issue_stage issue_stage_i (
        .clock       (clock),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .a_can_issue (a_can_issue),
        .b_can_issue (b_can_issue),
        .issue       (issue),
        .io_ready    (io_ready)
    );

    // --------------------
    // Operand banks.
    // --------------------

    operand_bank #(
        .write_base   (a_write_base)
    ) bank_a (
        .clock        (clock),
        .reset        (reset),
        .issue        (issue),
        .wb           (wb),
        .io_in_ready  (a_io_in_ready),
        .io_in_data   (a_io_in_data),
        .io_out_ready (a_io_out_ready),
        .can_issue    (a_can_issue),
        .operand      (a_operand),
        .io_rden      (a_io_rden),
        .io_wren      (a_io_wren),
        .io_out_data  (a_io_out_data)
    );

    operand_bank #(
        .write_base   (b_write_base)
    ) bank_b (
        .clock        (clock),
        .reset        (reset),
        .issue        (issue),
        .wb           (wb),
        .io_in_ready  (b_io_in_ready),
        .io_in_data   (b_io_in_data),
        .io_out_ready (b_io_out_ready),
        .can_issue    (b_can_issue),
        .operand      (b_operand),
        .io_rden      (b_io_rden),
        .io_wren      (b_io_wren),
        .io_out_data  (b_io_out_data)
    );

    // --------------------
    // ALU and result.
    // --------------------

    alu_stage alu_stage_i (
        .clock        (clock),
        .reset        (reset),
        .issue        (issue),
        .a_operand    (a_operand),
        .b_operand    (b_operand),
        .wb           (wb),
        .result       (result),
        .result_valid (result_valid),
        .result_d     (result_d)
    );

endmodule

//--- bench/datapath_cases.svh
// Columns are name, opcode, d, a, b, ready mask and issue on first presentation.
// Ready mask has A read in [1:0], B read in [3:2], A write in [5:4], B write in [7:6].

// --------------------
// Load both banks from the read ports.
// --------------------
add_case("load_a0",        pass_a, 12'd0,   8'd62,  8'd64, 8'hff, 1'b1);
add_case("load_a1",        pass_a, 12'd1,   8'd63,  8'd64, 8'hff, 1'b1);
add_case("load_b0",        pass_b, 12'd64,  8'd64,  8'd62, 8'hff, 1'b1);
add_case("load_b1",        pass_b, 12'd65,  8'd64,  8'd63, 8'hff, 1'b1);

// --------------------
// ALU on stored operands, both windows.
// --------------------
add_case("add_to_a",       add,    12'd2,   8'd0,   8'd0,  8'hff, 1'b1);
add_case("sub_to_b",       sub,    12'd66,  8'd1,   8'd1,  8'hff, 1'b1);
add_case("and_to_a",       and_op, 12'd3,   8'd0,   8'd1,  8'hff, 1'b1);
add_case("or_to_b",        or_op,  12'd67,  8'd1,   8'd0,  8'hff, 1'b1);
add_case("xor_to_a",       xor_op, 12'd4,   8'd2,   8'd2,  8'hff, 1'b1);
add_case("pass_a_to_b",    pass_a, 12'd68,  8'd3,   8'd64, 8'hff, 1'b1);
add_case("pass_b_to_a",    pass_b, 12'd5,   8'd64,  8'd4,  8'hff, 1'b1);
add_case("readback_a0",    pass_a, 12'd6,   8'd0,   8'd64, 8'hff, 1'b1);

// --------------------
// Writes to the I/O write ports.
// --------------------
add_case("wr_a_port0",     add,    12'd62,  8'd0,   8'd1,  8'hff, 1'b1);
add_case("wr_a_port1",     xor_op, 12'd63,  8'd2,   8'd0,  8'hff, 1'b1);
add_case("wr_b_port0",     or_op,  12'd126, 8'd1,   8'd2,  8'hff, 1'b1);
add_case("wr_b_port1",     pass_b, 12'd127, 8'd64,  8'd0,  8'hff, 1'b1);
add_case("port_to_port",   pass_a, 12'd62,  8'd63,  8'd64, 8'hff, 1'b1);

// --------------------
// Ports not ready, then re-presented.
// --------------------
add_case("annul_a_in",     pass_a, 12'd8,   8'd62,  8'd64, 8'hfe, 1'b0);
add_case("annul_b_in",     add,    12'd9,   8'd0,   8'd63, 8'hf7, 1'b0);
add_case("annul_a_out",    sub,    12'd63,  8'd0,   8'd0,  8'hdf, 1'b0);
add_case("annul_b_out",    and_op, 12'd126, 8'd1,   8'd1,  8'hbf, 1'b0);
add_case("unused_ports",   or_op,  12'd10,  8'd0,   8'd0,  8'h00, 1'b1);
add_case("readback_a8",    pass_a, 12'd14,  8'd8,   8'd64, 8'hff, 1'b1);

// --------------------
// Nop, high operand addresses and an unmapped destination.
// --------------------
add_case("nop",            nop,    12'd11,  8'd62,  8'd62, 8'hff, 1'b1);
add_case("nop_not_ready",  nop,    12'd62,  8'd62,  8'd63, 8'h00, 1'b1);
add_case("high_addr_a",    add,    12'd12,  8'd200, 8'd1,  8'hff, 1'b1);
add_case("high_addr_b",    or_op,  12'd69,  8'd3,   8'd64, 8'hff, 1'b1);
add_case("outside_window", add,    12'd300, 8'd0,   8'd0,  8'hff, 1'b1);
add_case("readback_a12",   pass_a, 12'd13,  8'd12,  8'd64, 8'hff, 1'b1);
add_case("readback_b5",    pass_b, 12'd15,  8'd64,  8'd5,  8'hff, 1'b1);

//--- bench/datapath_tb.sv
`timescale 1ns/1ps

module datapath_tb;

    import datapath_pkg::*;

    localparam int clock_period   = 40;
    localparam int reset_cycles   = 8;
    localparam int result_timeout = 4;
    // An annulled row is presented twice, so allow room for both passes.
    localparam int cycles_per_row = 12;
    localparam logic [7:0] all_ready = 8'hff;

    logic clock = 1'b0;
    logic reset;

    instr_t instr;
    logic   instr_valid;
    logic   io_ready;
    word_t  result;
    logic   result_valid;
    logic [dest_width-1:0] result_d;

    // Ready mask has A read in [1:0], B read in [3:2], A write in [5:4], B write in [7:6].
    logic  [io_port_count-1:0] a_in_ready, a_out_ready, a_io_rden, a_io_wren;
    logic  [io_port_count-1:0] b_in_ready, b_out_ready, b_io_rden, b_io_wren;
    word_t [io_port_count-1:0] a_in_data, a_io_out_data;
    word_t [io_port_count-1:0] b_in_data, b_io_out_data;

    // Stimulus table filled from datapath_cases.svh.
    string      case_name [$];
    instr_t     case_instr [$];
    logic [7:0] case_ready [$];
    logic       case_issue [$];

    // Expected contents of both banks.
    // The table reads only locations that it has written.
    word_t a_mem [bank_depth];
    word_t b_mem [bank_depth];
    word_t expected_result;

    always #(clock_period / 2) clock = ~clock;

    datapath_top dut (
        .clock          (clock),
        .reset          (reset),
        .instr          (instr),
        .instr_valid    (instr_valid),
        .io_ready       (io_ready),
        .result         (result),
        .result_valid   (result_valid),
        .result_d       (result_d),
        .a_io_in_ready  (a_in_ready),
        .a_io_rden      (a_io_rden),
        .a_io_in_data   (a_in_data),
        .a_io_out_ready (a_out_ready),
        .a_io_wren      (a_io_wren),
        .a_io_out_data  (a_io_out_data),
        .b_io_in_ready  (b_in_ready),
        .b_io_rden      (b_io_rden),
        .b_io_in_data   (b_in_data),
        .b_io_out_ready (b_out_ready),
        .b_io_wren      (b_io_wren),
        .b_io_out_data  (b_io_out_data)
    );

    // --------------------
    // Table and model.
    // --------------------

    task automatic add_case(string name, opcode_e op, logic [dest_width-1:0] d,
                            logic [src_width-1:0] a, logic [src_width-1:0] b,
                            logic [7:0] ready, logic issue);
        instr_t ins;
        ins.opcode = op;
        ins.d      = d;
        ins.a      = a;
        ins.b      = b;
        case_name.push_back(name);
        case_instr.push_back(ins);
        case_ready.push_back(ready);
        case_issue.push_back(issue);
    endtask

    task automatic load_cases();
        `include "datapath_cases.svh"
    endtask

    function automatic word_t alu_model(opcode_e op, word_t x, word_t y);
        word_t r;
        case (op)
            add:     r = x + y;
            sub:     r = x + ~y + word_t'(1);
            and_op:  r = x & y;
            or_op:   r = x | y;
            xor_op:  r = x ^ y;
            pass_a:  r = x;
            pass_b:  r = y;
            default: r = '0;
        endcase
        return r;
    endfunction

    // Reads RAM below 62, the read ports at 62 and 63 and zero above.
    function automatic word_t read_model(bit from_b, logic [src_width-1:0] addr);
        if (addr < 8'd62) begin
            return from_b ? b_mem[addr[5:0]] : a_mem[addr[5:0]];
        end
        if (addr < 8'd64) begin
            return from_b ? b_in_data[addr[0]] : a_in_data[addr[0]];
        end
        return '0;
    endfunction

    // --------------------
    // Compare tasks.
    // --------------------

    task automatic fail_run(string why);
        $display("Simulation failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected 0x%h, actual 0x%h", name, expected, actual);
            fail_run({name, " has the wrong value"});
        end
    endtask

    task automatic check_dest(string name, logic [dest_width-1:0] expected,
                              logic [dest_width-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            fail_run({name, " has the wrong destination"});
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            fail_run({name, " has the wrong level"});
        end
    endtask

    // --------------------
    // Row sequencing.
    // --------------------

    task automatic quiet_cycles(string name, int n);
        repeat (n) begin
            @(negedge clock);
            check_flag({name, " io_ready"}, 1'b0, io_ready);
            check_flag({name, " result_valid"}, 1'b0, result_valid);
            check_flag({name, " io_rden"}, 1'b0, |{a_io_rden, b_io_rden});
            check_flag({name, " io_wren"}, 1'b0, |{a_io_wren, b_io_wren});
        end
    endtask

    // Drives one presentation and checks the issue cycle.
    task automatic present_row(int i, logic [7:0] ready, logic exp_issue);
        instr_t ins;
        logic active;
        logic [io_port_count-1:0] exp_a_rden;
        logic [io_port_count-1:0] exp_b_rden;
        int p;
        ins         = case_instr[i];
        a_in_ready  = ready[1:0];
        b_in_ready  = ready[3:2];
        a_out_ready = ready[5:4];
        b_out_ready = ready[7:6];
        for (p = 0; p < io_port_count; p++) begin
            a_in_data[p] = word_t'($urandom);
            b_in_data[p] = word_t'($urandom);
        end
        instr       = ins;
        instr_valid = 1'b1;
        @(posedge clock);
        @(negedge clock);
        instr_valid = 1'b0;

        check_flag({case_name[i], " io_ready"}, exp_issue, io_ready);
        active     = exp_issue && (ins.opcode != nop);
        exp_a_rden = '0;
        exp_b_rden = '0;
        if (active && (ins.a == 8'd62 || ins.a == 8'd63)) begin
            exp_a_rden[ins.a[0]] = 1'b1;
        end
        if (active && (ins.b == 8'd62 || ins.b == 8'd63)) begin
            exp_b_rden[ins.b[0]] = 1'b1;
        end
        for (p = 0; p < io_port_count; p++) begin
            check_flag($sformatf("%s a_io_rden[%0d]", case_name[i], p),
                       exp_a_rden[p], a_io_rden[p]);
            check_flag($sformatf("%s b_io_rden[%0d]", case_name[i], p),
                       exp_b_rden[p], b_io_rden[p]);
        end
        expected_result = alu_model(ins.opcode, read_model(1'b0, ins.a),
                                    read_model(1'b1, ins.b));
    endtask

    task automatic wait_for_result(string name);
        int waited;
        waited = 0;
        while (result_valid !== 1'b1 && waited < result_timeout) begin
            @(negedge clock);
            waited++;
        end
        if (result_valid !== 1'b1) begin
            fail_run($sformatf("%s: no result within %0d cycles", name, result_timeout));
        end
    endtask

    task automatic wait_for_write(string name, bit to_b, bit port);
        int waited;
        int p;
        logic [io_port_count-1:0] exp_wren;
        waited = 0;
        while (!(|{a_io_wren, b_io_wren}) && waited < result_timeout) begin
            @(negedge clock);
            waited++;
        end
        if (!(|{a_io_wren, b_io_wren})) begin
            fail_run($sformatf("%s: no port write within %0d cycles", name, result_timeout));
        end
        exp_wren       = '0;
        exp_wren[port] = 1'b1;
        for (p = 0; p < io_port_count; p++) begin
            check_flag($sformatf("%s a_io_wren[%0d]", name, p),
                       to_b ? 1'b0 : exp_wren[p], a_io_wren[p]);
            check_flag($sformatf("%s b_io_wren[%0d]", name, p),
                       to_b ? exp_wren[p] : 1'b0, b_io_wren[p]);
        end
        check_word({name, " io_out_data"}, expected_result,
                   to_b ? b_io_out_data[port] : a_io_out_data[port]);
    endtask

    task automatic complete_row(int i);
        instr_t ins;
        logic [bank_addr_width-1:0] dest_local;
        logic in_window;
        logic to_b;
        ins = case_instr[i];
        if (ins.opcode == nop) begin
            quiet_cycles({case_name[i], " nop"}, 4);
        end else begin
            wait_for_result(case_name[i]);
            check_word({case_name[i], " result"}, expected_result, result);
            check_dest({case_name[i], " result_d"}, ins.d, result_d);
            // Both windows are 64 aligned, so the low six bits are the local address.
            in_window  = (ins.d < 12'd128);
            to_b       = (ins.d >= 12'd64);
            dest_local = ins.d[5:0];
            if (in_window && dest_local >= 6'd62) begin
                wait_for_write(case_name[i], to_b, dest_local[0]);
            end else if (in_window && to_b) begin
                b_mem[dest_local] = expected_result;
            end else if (in_window) begin
                a_mem[dest_local] = expected_result;
            end
            quiet_cycles({case_name[i], " idle"}, 3);
        end
    endtask

    // --------------------
    // Main sequence.
    // --------------------

    initial begin
        int watchdog_cycles;
        reset       = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        a_in_ready  = '1;
        b_in_ready  = '1;
        a_out_ready = '1;
        b_out_ready = '1;
        a_in_data   = '0;
        b_in_data   = '0;
        void'($urandom(32'he3df_b892));
        load_cases();

        watchdog_cycles = case_name.size() * cycles_per_row + reset_cycles + 8;
        fork
            begin
                #(watchdog_cycles * clock_period);
                fail_run("Watchdog expired before the last table row finished");
            end
        join_none

        repeat (reset_cycles) @(negedge clock);
        reset = 1'b0;
        quiet_cycles("after_reset", 4);

        for (int i = 0; i < case_name.size(); i++) begin
            present_row(i, case_ready[i], case_issue[i]);
            if (!case_issue[i]) begin
                // An annulled row must leave no trace before it comes back.
                quiet_cycles({case_name[i], " annulled"}, 4);
                present_row(i, all_ready, 1'b1);
            end
            complete_row(i);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- sim.f
+incdir+bench
hdl/datapath_pkg.sv
hdl/issue_stage.sv
hdl/operand_bank.sv
hdl/alu_stage.sv
hdl/datapath_top.sv
bench/datapath_tb.sv

//--- Makefile
TOP := datapath_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sim.f -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
